// File: rtl/bus_types_pkg.sv
////////////////////////////////////////////////////////////
//
// Bus board external bus types
// Widths, address and data words, bus strobes and the
// I/O device selects seen on the backplane side
//
////////////////////////////////////////////////////////////

`default_nettype none

package bus_types_pkg;

   localparam int ADDR_W   = 24;             // External address bus
   localparam int DATA_W   = 16;             // Data bus and processor bus
   localparam int OFFSET_W = 16;             // Address register offset
   localparam int BANK_W   = 8;              // Bank extension, ab[23:16]

   typedef logic [ADDR_W-1:0]   addr_t;      // Full 24-bit address
   typedef logic [OFFSET_W-1:0] offset_t;    // Low 16 bits of AR
   typedef logic [BANK_W-1:0]   bank_t;      // One bank register
   typedef logic [DATA_W-1:0]   data_t;      // Bus word

   // Bus transaction levels, active high here
   typedef struct packed {
      logic mem;                             // Memory space cycle
      logic io;                              // I/O space cycle
      logic wr;                              // Write strobe
      logic rd;                              // Read strobe
   } bus_ctl_t;

   // I/O space decode, one 256-word window each
   typedef struct packed {
      logic sysdev;                          // 000-0FF
      logic iodev1xx;                        // 100-1FF
      logic iodev2xx;                        // 200-2FF
      logic iodev3xx;                        // 300-3FF
   } dev_sel_t;

endpackage

`default_nettype wire

// File: rtl/ucode_pkg.sv
////////////////////////////////////////////////////////////
//
// Microcode side types
// Field types, register address codes, the decoded step
// and the constant store contents
//
////////////////////////////////////////////////////////////

`default_nettype none

package ucode_pkg;

   typedef logic [4:0] reg_addr_t;           // raddr / waddr field
   typedef logic [3:0] action_t;             // Carried only
   typedef logic [2:0] ir_idx_t;             // IR[2:0], bank select

   typedef struct packed {
      reg_addr_t raddr;                      // Internal bus source
      reg_addr_t waddr;                      // Internal bus destination
      action_t   action;
      logic      mem;                        // Memory space
      logic      io;                         // I/O space
      logic      rd;                         // Bus read request
   } ucode_t;

   localparam reg_addr_t WADDR_AR  = 5'd1;   // Code 0 means no write
   localparam reg_addr_t WADDR_MBN = 5'd2;
   localparam reg_addr_t WADDR_DR  = 5'd3;

   localparam reg_addr_t RADDR_DR      = 5'd1;
   localparam reg_addr_t RADDR_MBN     = 5'd2;
   localparam reg_addr_t RADDR_AR      = 5'd3;
   localparam reg_addr_t RADDR_CS_BASE = 5'd24;  // 24..31 constant store

   // Index 0 is the last entry of the list
   localparam bus_types_pkg::data_t [7:0] CONST_TABLE = {
      16'hFFFF, 16'h8000, 16'h7FFF, 16'h00FF,
      16'h0004, 16'h0002, 16'h0001, 16'h0000
   };

   // One registered step
   typedef struct packed {
      ucode_t               uc;              // Word as sampled
      ir_idx_t              ir;              // Bank register index
      bus_types_pkg::data_t ibus;            // Processor bus value
      logic                 wr_ar;           // AR load
      logic                 wr_mbn;          // Bank register load
      logic                 wr_dr;           // Bus write
      logic                 rd_sel;          // Valid internal bus read
   } decoded_t;

endpackage

`default_nettype wire

// File: rtl/ucode_decode.sv
////////////////////////////////////////////////////////////
//
// Microcode decode, input side of the bus board
// Registers the step and turns the register addresses
// into write strobes and a read flag, holding while busy
//
////////////////////////////////////////////////////////////

`default_nettype none

module ucode_decode (
   input  logic                  clk,
   input  logic                  rst_n,
   input  ucode_pkg::ucode_t     ucode,
   input  bus_types_pkg::data_t  ibus_in,
   input  ucode_pkg::ir_idx_t    ir,
   input  logic                  busy,
   output ucode_pkg::decoded_t   decoded
);

   import ucode_pkg::*;

   logic wr_ar_n;                            // Next-step flags
   logic wr_mbn_n;
   logic wr_dr_n;
   logic rd_sel_n;

   always_comb begin
      wr_ar_n  = (ucode.waddr == WADDR_AR);
      wr_mbn_n = (ucode.waddr == WADDR_MBN);
      wr_dr_n  = (ucode.waddr == WADDR_DR);
      case (ucode.raddr)
         RADDR_DR:           rd_sel_n = ucode.rd;   // DR needs a bus read
         RADDR_MBN,
         RADDR_AR:           rd_sel_n = 1'b1;
         default:            rd_sel_n = (ucode.raddr >= RADDR_CS_BASE);
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         decoded <= '0;
      end else if (busy) begin
         decoded.wr_ar  <= 1'b0;             // Fields held, step already issued
         decoded.wr_mbn <= 1'b0;
         decoded.wr_dr  <= 1'b0;
         decoded.rd_sel <= 1'b0;
      end else begin
         decoded <= '{uc: ucode, ir: ir, ibus: ibus_in,
                      wr_ar: wr_ar_n, wr_mbn: wr_mbn_n,
                      wr_dr: wr_dr_n, rd_sel: rd_sel_n};
      end
   end

   // A bus cycle is either a read or a write
   a_no_dr_rw: assert property (@(posedge clk) disable iff (!rst_n)
      !(decoded.wr_dr && decoded.rd_sel && decoded.uc.raddr == RADDR_DR));

endmodule

`default_nettype wire

// File: rtl/addr_reg.sv
////////////////////////////////////////////////////////////
//
// Address register
// Loads the 16-bit offset from the processor bus, adds the
// bank extension in memory space and decodes I/O devices
//
////////////////////////////////////////////////////////////

`default_nettype none

module addr_reg (
   input  logic                    clk,
   input  logic                    rst_n,
   input  ucode_pkg::decoded_t     decoded,
   input  bus_types_pkg::bank_t    bank,
   output bus_types_pkg::offset_t  offset,
   output bus_types_pkg::addr_t    ab,
   output bus_types_pkg::dev_sel_t dev_sel
);

   import bus_types_pkg::*;

   offset_t  new_off;                        // Offset being loaded
   logic     io_win;                         // Inside the 1K I/O window
   dev_sel_t new_sel;

   always_comb begin
      new_off = decoded.ibus;
      io_win  = (new_off[15:10] == '0);      // Only 000-3FF decodes
      new_sel = '0;
      if (decoded.uc.io && io_win) begin
         case (new_off[9:8])
            2'd0:    new_sel.sysdev   = 1'b1;
            2'd1:    new_sel.iodev1xx = 1'b1;
            2'd2:    new_sel.iodev2xx = 1'b1;
            default: new_sel.iodev3xx = 1'b1;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ab      <= '0;
         dev_sel <= '0;
      end else if (decoded.wr_ar) begin
         ab      <= decoded.uc.io ? {BANK_W'(0), new_off}   // No banking for I/O
                                  : {bank, new_off};
         dev_sel <= new_sel;
      end
   end

   assign offset = ab[OFFSET_W-1:0];         // Offset is the low part of AR

   a_dev_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(dev_sel));

endmodule

`default_nettype wire

// File: rtl/mbu.sv
////////////////////////////////////////////////////////////
//
// Memory banking unit
// Bank registers written from the processor bus, indexed
// by IR[2:0]; AR writes look up the bank by the top
// offset bits
//
////////////////////////////////////////////////////////////

`default_nettype none

module mbu #(
   parameter int BANKS = 8                   // Power of two, 2..8
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  ucode_pkg::decoded_t  decoded,
   output bus_types_pkg::bank_t bank,
   output bus_types_pkg::bank_t mbn_rd
);

   import bus_types_pkg::*;

   localparam int IDX_W = $clog2(BANKS);

   bank_t            regs [BANKS];           // Bank registers
   logic [IDX_W-1:0] sel_idx;                // From IR
   logic [IDX_W-1:0] lk_idx;                 // From offset top bits

   assign sel_idx = decoded.ir[IDX_W-1:0];
   assign lk_idx  = decoded.ibus[DATA_W-1 -: IDX_W];  // Bits 15:13 for 8 banks

   ////////////////////////////////////////////////////////////
   // Register file

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < BANKS; i++) begin
            regs[i] <= '0;                   // All banks start at 0
         end
      end else if (decoded.wr_mbn) begin
         regs[sel_idx] <= decoded.ibus[BANK_W-1:0];  // Low byte only
      end
   end

   ////////////////////////////////////////////////////////////
   // Lookup and readback

   assign bank   = regs[lk_idx];             // Sampled by AR at the same edge
   assign mbn_rd = regs[sel_idx];            // MBN read source

   // IR comes from the control unit
   a_ir_known: assert property (@(posedge clk) disable iff (!rst_n)
      decoded.wr_mbn |-> !$isunknown(decoded.ir));

endmodule

`default_nettype wire

// File: rtl/ibus_source.sv
////////////////////////////////////////////////////////////
//
// Internal bus source
// Picks the read value for the step and registers it
// with a one-cycle valid level
//
////////////////////////////////////////////////////////////

`default_nettype none

module ibus_source (
   input  logic                   clk,
   input  logic                   rst_n,
   input  ucode_pkg::decoded_t    decoded,
   input  bus_types_pkg::data_t   db_in,
   input  bus_types_pkg::offset_t offset,
   input  bus_types_pkg::bank_t   mbn_rd,
   output bus_types_pkg::data_t   ibus_out,
   output logic                   ibus_valid
);

   import bus_types_pkg::*;
   import ucode_pkg::*;

   logic [2:0] cs_idx;                       // Constant store entry
   data_t      src;

   always_comb begin
      cs_idx = 3'(decoded.uc.raddr - RADDR_CS_BASE);
      case (decoded.uc.raddr)
         RADDR_DR:  src = db_in;             // Sampled at the execute edge
         RADDR_MBN: src = data_t'(mbn_rd);   // Zero extended
         RADDR_AR:  src = data_t'(offset);
         default:   src = (decoded.uc.raddr >= RADDR_CS_BASE) ? CONST_TABLE[cs_idx]
                                                              : '0;
      endcase
   end

   always_ff @(posedge clk) begin
      ibus_out <= src;                       // Ignored unless valid
   end

   always_ff @(posedge clk) begin
      if (!rst_n) ibus_valid <= 1'b0;
      else        ibus_valid <= decoded.rd_sel;  // One pulse per read step
   end

endmodule

`default_nettype wire

// File: rtl/databus.sv
////////////////////////////////////////////////////////////
//
// Data bus driver, output side of the bus board
// Drives write data and the bus strobes, and stretches
// the cycle with busy while wait states are asserted
//
////////////////////////////////////////////////////////////

`default_nettype none

module databus (
   input  logic                   clk,
   input  logic                   rst_n,
   input  ucode_pkg::decoded_t    decoded,
   input  logic                   ws,
   output bus_types_pkg::data_t   db_out,
   output bus_types_pkg::bus_ctl_t bus_ctl,
   output logic                   busy
);

   import ucode_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,                               // No bus cycle
      ST_WRITE,                              // wr driven
      ST_READ                                // rd driven
   } bus_state_t;

   bus_state_t state;
   logic       rd_dr;                        // DR read this step
   logic       hold;                         // Wait state extends the cycle

   assign rd_dr = decoded.rd_sel && (decoded.uc.raddr == RADDR_DR);
   assign hold  = (state != ST_IDLE) && ws;

   ////////////////////////////////////////////////////////////
   // Bus cycle FSM

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         bus_ctl <= '0;
         busy    <= 1'b0;
      end else if (hold) begin
         busy <= 1'b1;                       // Strobes stay as they are
      end else if (decoded.wr_dr) begin
         state   <= ST_WRITE;
         bus_ctl <= '{mem: decoded.uc.mem, io: decoded.uc.io, wr: 1'b1, rd: 1'b0};
         busy    <= 1'b0;
      end else if (rd_dr) begin
         state   <= ST_READ;
         bus_ctl <= '{mem: decoded.uc.mem, io: decoded.uc.io, wr: 1'b0, rd: 1'b1};
         busy    <= 1'b0;
      end else begin
         state   <= ST_IDLE;                 // Cycle ends on ws low
         bus_ctl <= '0;
         busy    <= 1'b0;
      end
   end

   // Write data
   always_ff @(posedge clk) begin
      if (decoded.wr_dr && !hold) db_out <= decoded.ibus;
   end

   a_no_wr_rd: assert property (@(posedge clk) disable iff (!rst_n)
      !(bus_ctl.wr && bus_ctl.rd));

endmodule

`default_nettype wire

// File: rtl/card_bus.sv
////////////////////////////////////////////////////////////
//
// Bus board top level
// Microcode decode, address register, banking unit,
// internal bus source and data bus driver
//
////////////////////////////////////////////////////////////

`default_nettype none

module card_bus #(
   parameter int BANKS = 8                   // Bank registers in the MBU
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  ucode_pkg::ucode_t       ucode,    // Microcode step
   input  bus_types_pkg::data_t    ibus_in,  // Processor bus
   input  ucode_pkg::ir_idx_t      ir,       // IR[2:0]
   input  bus_types_pkg::data_t    db_in,    // Data bus in
   input  logic                    ws,       // Wait state
   output bus_types_pkg::addr_t    ab,
   output bus_types_pkg::dev_sel_t dev_sel,
   output bus_types_pkg::data_t    db_out,
   output bus_types_pkg::bus_ctl_t bus_ctl,
   output logic                    busy,
   output bus_types_pkg::data_t    ibus_out,
   output logic                    ibus_valid
);

   import bus_types_pkg::*;
   import ucode_pkg::*;

   decoded_t decoded;                        // Registered step
   bank_t    bank;                           // MBU lookup for AR
   bank_t    mbn_rd;                         // MBU readback
   offset_t  offset;                         // AR low word

   ////////////////////////////////////////////////////////////
   // Blocks

   ucode_decode ucode_decode_i (.clk, .rst_n, .ucode, .ibus_in, .ir, .busy, .decoded);

   addr_reg addr_reg_i (.clk, .rst_n, .decoded, .bank, .offset, .ab, .dev_sel);

   mbu #(.BANKS(BANKS)) mbu_i (.clk, .rst_n, .decoded, .bank, .mbn_rd);

   ibus_source ibus_source_i (.clk, .rst_n, .decoded, .db_in, .offset, .mbn_rd,
                              .ibus_out, .ibus_valid);

   databus databus_i (.clk, .rst_n, .decoded, .ws, .db_out, .bus_ctl, .busy);

endmodule

`default_nettype wire

// File: tests/card_bus_checks.svh
////////////////////////////////////////////////////////////
//
// Bus board testbench compare tasks
// One compare task per result type and the error counters
//
////////////////////////////////////////////////////////////

`ifndef CARD_BUS_CHECKS_SVH
`define CARD_BUS_CHECKS_SVH

int value_errors = 0;                        // Wrong values seen
int other_errors = 0;                        // Protocol and file problems

task automatic report_failure(input string what);
   other_errors++;
   $display("Failure at %0t: %s", $time, what);
endtask

task automatic check_addr(input bus_types_pkg::addr_t got,
                          input bus_types_pkg::addr_t exp, input string name);
   if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
   end
endtask

task automatic check_data(input bus_types_pkg::data_t got,
                          input bus_types_pkg::data_t exp, input string name);
   if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
   end
endtask

task automatic check_dev(input bus_types_pkg::dev_sel_t got,
                         input bus_types_pkg::dev_sel_t exp, input string name);
   if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
   end
endtask

task automatic check_ctl(input bus_types_pkg::bus_ctl_t got,
                         input bus_types_pkg::bus_ctl_t exp, input string name);
   if (got !== exp) begin
      value_errors++;                        // Order is mem io wr rd
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
   end
endtask

`endif

// File: tests/card_bus_tb.sv
////////////////////////////////////////////////////////////
//
// Bus board testbench
// Reads microcode steps from the stimulus file, drives the
// DUT and checks address, data and strobe results
//
////////////////////////////////////////////////////////////

`default_nettype none

module card_bus_tb;

   import bus_types_pkg::*;
   import ucode_pkg::*;

   typedef struct packed {
      reg_addr_t raddr;
      reg_addr_t waddr;
      logic      mem;
      logic      io;
      logic      rd;
      data_t     ibus;                       // Processor bus value
      ir_idx_t   ir;
      data_t     db;                         // db_in for the step
      logic [7:0] ws_cnt;                    // Wait state edges
      logic      has_exp;
      addr_t     exp;                        // ab, db_out or ibus_out
   } step_t;

   logic     clk = 1'b0;
   logic     rst_n;
   ucode_t   ucode;
   data_t    ibus_in;
   ir_idx_t  ir;
   data_t    db_in;
   logic     ws;
   addr_t    ab;
   dev_sel_t dev_sel;
   data_t    db_out;
   bus_ctl_t bus_ctl;
   logic     busy;
   data_t    ibus_out;
   logic     ibus_valid;

   integer   seed = 32'hb8da_ba21;
   step_t    steps[$];
   logic     loaded = 1'b0;

   `include "card_bus_checks.svh"

   card_bus #(.BANKS(8)) card_bus_i (
      .clk, .rst_n, .ucode, .ibus_in, .ir, .db_in, .ws,
      .ab, .dev_sel, .db_out, .bus_ctl, .busy, .ibus_out, .ibus_valid
   );

   always #50 clk = ~clk;                    // 100 unit period

   // Device select from the I/O decode rules
   function automatic dev_sel_t expected_dev(input offset_t off, input logic io);
      dev_sel_t d;
      d = '0;
      if (io && off[15:10] == 6'd0) begin
         case (off[9:8])
            2'd0:    d.sysdev   = 1'b1;
            2'd1:    d.iodev1xx = 1'b1;
            2'd2:    d.iodev2xx = 1'b1;
            default: d.iodev3xx = 1'b1;
         endcase
      end
      return d;
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus file

   task automatic load_steps();
      int    fd;
      int    n;
      string line;
      string tok;
      int    f_r, f_w, f_m, f_i, f_rd, f_ib, f_ir, f_db, f_ws;
      int    ev;
      step_t s;
      fd = $fopen("tests/card_bus_stimulus.txt", "r");
      if (fd == 0) begin
         report_failure("stimulus file could not be opened");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() < 2 || line.getc(0) == "#") continue;  // Blank or comment
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %d %s",
                     f_r, f_w, f_m, f_i, f_rd, f_ib, f_ir, f_db, f_ws, tok);
         if (n != 10) begin
            report_failure({"malformed stimulus line: ", line});
            continue;
         end
         ev = 0;
         s.has_exp = (tok != "-");           // Dash means nothing to compare
         if (s.has_exp) n = $sscanf(tok, "%h", ev);
         s.raddr  = reg_addr_t'(f_r);
         s.waddr  = reg_addr_t'(f_w);
         s.mem    = f_m[0];
         s.io     = f_i[0];
         s.rd     = f_rd[0];
         s.ibus   = data_t'(f_ib);
         s.ir     = ir_idx_t'(f_ir);
         s.db     = data_t'(f_db);
         s.ws_cnt = 8'(f_ws);
         s.exp    = addr_t'(ev);
         steps.push_back(s);
      end
      $fclose(fd);
   endtask

   task automatic drive_idle();
      ucode   = '{raddr: 5'd0, waddr: 5'd0, action: action_t'($random(seed)),
                  mem: 1'b0, io: 1'b0, rd: 1'b0};
      ibus_in = data_t'($random(seed));      // Don't care without a write
   endtask

   ////////////////////////////////////////////////////////////
   // One microcode step, results two edges later

   task automatic run_step(input step_t s);
      bus_ctl_t exp_ctl;
      logic     rd_dr;
      logic     wr_dr;
      logic     is_read;
      int       busy_cycles;
      rd_dr   = (s.raddr == RADDR_DR) && s.rd;
      wr_dr   = (s.waddr == WADDR_DR);
      is_read = (s.raddr == RADDR_DR) ? s.rd
              : (s.raddr == RADDR_MBN || s.raddr == RADDR_AR || s.raddr >= RADDR_CS_BASE);
      exp_ctl = '0;
      if (wr_dr)      exp_ctl = '{mem: s.mem, io: s.io, wr: 1'b1, rd: 1'b0};
      else if (rd_dr) exp_ctl = '{mem: s.mem, io: s.io, wr: 1'b0, rd: 1'b1};
      busy_cycles = 0;
      @(posedge clk);
      #10;
      ucode   = '{raddr: s.raddr, waddr: s.waddr, action: action_t'($random(seed)),
                  mem: s.mem, io: s.io, rd: s.rd};
      ibus_in = (s.waddr == 5'd0) ? data_t'($random(seed)) : s.ibus;
      ir      = (s.waddr == WADDR_MBN || s.raddr == RADDR_MBN) ? s.ir
                                                               : ir_idx_t'($random(seed));
      db_in   = s.db;                        // Held until the read edge
      ws      = 1'b0;
      @(posedge clk);                        // Word sampled
      #10;
      drive_idle();
      @(posedge clk);                        // Word executed
      #10;
      ws = (s.ws_cnt != 8'd0);
      @(negedge clk);
      check_ctl(bus_ctl, exp_ctl, "bus_ctl");
      if (busy) report_failure("busy high before any wait state");
      if (is_read && !ibus_valid) report_failure("ibus_valid low on a read step");
      if (!is_read && ibus_valid) report_failure("ibus_valid high without a read");
      if (is_read && s.has_exp) check_data(ibus_out, data_t'(s.exp), "ibus_out");
      if (s.waddr == WADDR_AR) begin
         if (s.has_exp) check_addr(ab, s.exp, "ab");
         check_dev(dev_sel, expected_dev(offset_t'(s.ibus), s.io), "dev_sel");
      end
      if (wr_dr && s.has_exp) check_data(db_out, data_t'(s.exp), "db_out");
      // Stretched cycle, ws high for ws_cnt edges
      for (int i = 0; i < int'(s.ws_cnt); i++) begin
         @(posedge clk);
         #10;
         if (i == int'(s.ws_cnt) - 1) ws = 1'b0;
         @(negedge clk);
         if (busy) busy_cycles++;
         check_ctl(bus_ctl, exp_ctl, "bus_ctl");
      end
      if (busy_cycles != int'(s.ws_cnt))
         report_failure($sformatf("busy lasted %0d cycles instead of %0d",
                                  busy_cycles, s.ws_cnt));
      @(posedge clk);
      @(negedge clk);                        // Cycle over, read pulse gone
      check_ctl(bus_ctl, bus_ctl_t'(4'b0000), "bus_ctl");
      if (busy) report_failure("busy still high after the wait states");
      if (ibus_valid) report_failure("ibus_valid longer than one cycle");
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial begin
      rst_n   = 1'b0;
      ucode   = '0;
      ibus_in = '0;
      ir      = '0;
      db_in   = '0;
      ws      = 1'b0;
      load_steps();
      loaded = 1'b1;
      repeat (16) @(posedge clk);
      #10;
      rst_n = 1'b1;
      foreach (steps[i]) run_step(steps[i]);
      $display("Checks done with %0d value errors and %0d other errors",
               value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      wait (loaded);
      #((steps.size() + 16) * 20 * 100);
      $display("Watchdog expired, the run did not finish in time");
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/card_bus_stimulus.txt
# raddr waddr mem io rd ibus_in ir db_in ws_edges expect (hex, ws decimal)
# expect is ab on AR writes, db_out on DR writes, ibus_out on reads, - for none
02 00 0 0 0 0000 0 0000 0 0000
02 00 0 0 0 0000 3 0000 0 0000
02 00 0 0 0 0000 7 0000 0 0000
18 00 0 0 0 0000 0 0000 0 0000
19 00 0 0 0 0000 0 0000 0 0001
1a 00 0 0 0 0000 0 0000 0 0002
1b 00 0 0 0 0000 0 0000 0 0004
1c 00 0 0 0 0000 0 0000 0 00ff
1d 00 0 0 0 0000 0 0000 0 7fff
1e 00 0 0 0 0000 0 0000 0 8000
1f 00 0 0 0 0000 0 0000 0 ffff
00 02 0 0 0 12a5 1 0000 0 -
00 02 0 0 0 3c77 5 0000 0 -
00 02 0 0 0 ffff 7 0000 0 -
02 00 0 0 0 0000 1 0000 0 00a5
02 00 0 0 0 0000 5 0000 0 0077
02 00 0 0 0 0000 7 0000 0 00ff
00 01 1 0 0 2345 0 0000 0 a52345
00 01 1 0 0 a000 0 0000 0 77a000
00 01 1 0 0 e123 0 0000 0 ffe123
03 00 0 0 0 0000 0 0000 0 e123
00 01 0 1 0 0150 0 0000 0 000150
00 01 0 1 0 0300 0 0000 0 000300
00 01 0 1 0 0400 0 0000 0 000400
00 01 0 1 0 0000 0 0000 0 000000
00 01 0 1 0 e2ff 0 0000 0 00e2ff
00 03 1 0 0 beef 0 0000 3 beef
00 03 0 1 0 1234 0 0000 0 1234
00 03 1 0 0 5a5a 0 0000 1 5a5a
01 00 1 0 1 0000 0 c0de 0 c0de
01 00 0 1 1 0000 0 0042 2 0042
05 00 0 0 0 0000 0 0000 0 -

// File: sources.f
rtl/bus_types_pkg.sv
rtl/ucode_pkg.sv
rtl/ucode_decode.sv
rtl/addr_reg.sv
rtl/mbu.sv
rtl/ibus_source.sv
rtl/databus.sv
rtl/card_bus.sv
+incdir+tests
tests/card_bus_tb.sv

// File: Makefile
# Verilator build and run for the bus board testbench

VERILATOR ?= verilator
TOP       ?= card_bus_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): sources.f $(wildcard rtl/*.sv) $(wildcard tests/*.sv tests/*.svh)
	$(VERILATOR) $(VFLAGS) -f sources.f --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
